// File: common/loader_params.svh
// Loader sizing constants
// SD status bit positions and cartridge memory map
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// ====================
// Flow control
// ====================
`define LOADER_FIFO_DEPTH   4      // Reader to parser queue entries
`define LOADER_MEM_CREDITS  4      // Initial write credits toward memory

// ====================
// SD card
// ====================
`define LOADER_SECTOR_BYTES 512
`define LOADER_ST_INIT_BUSY  4     // Card init still running
`define LOADER_ST_BLOCK_BUSY 5     // Block transfer in progress
`define LOADER_ST_RX_READY   6     // Received byte waiting

// ====================
// Cartridge memory map
// ====================
`define LOADER_CHR_BASE 22'h200000 // CHR follows the 2 MB PRG window

`endif

// File: common/loader_pkg.sv
// Shared loader types
// Byte, address and sector types, mapper flag layout, SD register map
`default_nettype none

package loader_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [21:0] load_addr_t;
  typedef logic [15:0] sector_t;       // Sector number or count
  typedef logic [23:0] sd_block_addr_t;

  // Mapper flags as handed to the cartridge mapper logic
  typedef struct packed {
    logic [7:0] zero;
    logic [3:0] flags7_lo;
    logic [3:0] flags6_lo;
    logic       has_chr_ram;
    logic       mirroring;
    logic [2:0] chr_size;
    logic [2:0] prg_size;
    logic [7:0] mapper;
  } mapper_flags_t;

  // SD controller register addresses
  typedef enum logic [2:0] {
    SD_REG_DATA     = 3'd0,
    SD_REG_CMD      = 3'd1,          // Command on write, status on read
    SD_REG_ADDR_LO  = 3'd2,
    SD_REG_ADDR_MID = 3'd3,
    SD_REG_ADDR_HI  = 3'd4
  } sd_reg_e;

endpackage

`default_nettype wire

// File: cart_loader/credit_fifo.sv
// Credited byte FIFO
// Circular store that returns one credit per popped entry
`timescale 1ns/100ps
`default_nettype none
`include "loader_params.svh"

module credit_fifo (
  input  wire                    clk,
  input  wire                    clk_spi,
  input  wire                    byte_valid,
  input  wire loader_pkg::byte_t byte_data,
  input  wire                    fifo_pop,
  output logic                   fifo_valid,
  output loader_pkg::byte_t      fifo_data,
  output logic                   byte_credit
);

  localparam int DEPTH = `LOADER_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  loader_pkg::byte_t mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;     // One extra bit to tell full from empty

  assign fifo_valid  = (count != '0);
  assign fifo_data   = mem[rd_ptr];
  assign byte_credit = fifo_pop && fifo_valid;

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (byte_valid) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
      if (byte_credit) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(byte_valid) - (PTR_W+1)'(byte_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid) mem[wr_ptr] <= byte_data;
  end

  // Sender credit count must keep us from overflowing
  a_no_write_full: assert property (@(posedge clk) disable iff (clk_spi)
    byte_valid |-> count < (PTR_W+1)'(DEPTH));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (clk_spi)
    fifo_pop |-> fifo_valid);

endmodule

`default_nettype wire

// File: cart_loader/ines_parser.sv
// iNES header parser and cartridge memory writer
// Header checks, mapper flags, PRG/CHR addressing, memory credits
`timescale 1ns/100ps
`default_nettype none
`include "loader_params.svh"

module ines_parser (
  input  wire                    clk,
  input  wire                    clk_spi,
  input  wire                    fifo_valid,
  input  wire loader_pkg::byte_t fifo_data,
  input  wire                    mem_credit,
  output logic                   fifo_pop,
  output logic                   load_write,
  output loader_pkg::load_addr_t load_addr,
  output loader_pkg::byte_t      load_data,
  output loader_pkg::mapper_flags_t mapper_flags,
  output loader_pkg::sector_t    total_sectors,
  output logic                   done,
  output logic                   error
);

  localparam int CRED_W = $clog2(`LOADER_MEM_CREDITS + 1);

  typedef enum logic [1:0] {ST_HDR, ST_PRG, ST_CHR, ST_FIN} state_e;

  state_e                 state;
  loader_pkg::byte_t      hdr [16];
  logic [3:0]             hdr_idx;
  logic                   hdr_valid;
  logic [21:0]            remaining;     // Bytes left in current section
  loader_pkg::load_addr_t wr_addr;
  logic [CRED_W-1:0]      credits;
  logic                   take_data;
  logic                   hdr_ok;
  loader_pkg::byte_t      prg_units;
  loader_pkg::byte_t      chr_units;

  // Smallest n with units <= 2**n, capped at 7
  function automatic logic [2:0] size_code(input loader_pkg::byte_t units);
    logic [2:0] code;
    code = 3'd7;
    for (int n = 6; n >= 0; n--) begin
      if ({1'b0, units} <= (9'd1 << n)) code = 3'(n);
    end
    return code;
  endfunction

  assign prg_units = hdr[4];
  assign chr_units = hdr[5];
  assign hdr_ok = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) && (hdr[2] == 8'h53) &&
                  (hdr[3] == 8'h1A) && !hdr[6][2] && !hdr[6][3];

  // A write already in flight holds one credit
  assign take_data = (state == ST_PRG || state == ST_CHR) && fifo_valid &&
                     (credits > CRED_W'(load_write));
  assign fifo_pop  = take_data || (fifo_valid && (state == ST_HDR || state == ST_FIN));

  assign mapper_flags.zero        = '0;
  assign mapper_flags.flags7_lo   = hdr[7][3:0];
  assign mapper_flags.flags6_lo   = hdr[6][3:0];
  assign mapper_flags.has_chr_ram = (chr_units == '0);
  assign mapper_flags.mirroring   = hdr[6][0];
  assign mapper_flags.chr_size    = size_code(chr_units);
  assign mapper_flags.prg_size    = size_code(prg_units);
  assign mapper_flags.mapper      = {hdr[7][7:4], hdr[6][7:4]};

  // 32 sectors per 16 KB PRG unit, 16 per 8 KB CHR unit, plus the header sector
  assign total_sectors = hdr_valid ?
      ({3'b0, prg_units, 5'b0} + {4'b0, chr_units, 4'b0} + 16'd1) : '0;

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      credits <= CRED_W'(`LOADER_MEM_CREDITS);
    end else begin
      credits <= credits + CRED_W'(mem_credit) - CRED_W'(load_write);
    end
  end

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      state      <= ST_HDR;
      hdr_idx    <= '0;
      hdr_valid  <= 1'b0;
      remaining  <= '0;
      wr_addr    <= '0;
      load_write <= 1'b0;
      done       <= 1'b0;
      error      <= 1'b0;
    end else begin
      load_write <= take_data;
      if (state == ST_FIN && !error) done <= 1'b1;
      case (state)
        ST_HDR: if (fifo_valid) begin
          hdr_idx <= hdr_idx + 1'b1;
          if (hdr_idx == 4'd15) begin
            if (!hdr_ok) begin
              error <= 1'b1;
              state <= ST_FIN;
            end else begin
              hdr_valid <= 1'b1;
              wr_addr   <= '0;
              if (prg_units != '0) begin
                remaining <= {prg_units, 14'b0};
                state     <= ST_PRG;
              end else if (chr_units != '0) begin
                remaining <= {1'b0, chr_units, 13'b0};
                wr_addr   <= `LOADER_CHR_BASE;
                state     <= ST_CHR;
              end else begin
                state <= ST_FIN;
              end
            end
          end
        end
        ST_PRG: if (take_data) begin
          remaining <= remaining - 1'b1;
          wr_addr   <= wr_addr + 1'b1;
          if (remaining == 22'd1) begin
            if (chr_units != '0) begin
              remaining <= {1'b0, chr_units, 13'b0};
              wr_addr   <= `LOADER_CHR_BASE;
              state     <= ST_CHR;
            end else begin
              state <= ST_FIN;              // CHR RAM cart
            end
          end
        end
        ST_CHR: if (take_data) begin
          remaining <= remaining - 1'b1;
          wr_addr   <= wr_addr + 1'b1;
          if (remaining == 22'd1) state <= ST_FIN;
        end
        default: ;                          // Drain sector padding
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_HDR && fifo_valid) hdr[hdr_idx] <= fifo_data;
    if (take_data) begin
      load_data <= fifo_data;
      load_addr <= wr_addr;
    end
  end

  a_write_has_credit: assert property (@(posedge clk) disable iff (clk_spi)
    load_write |-> credits != '0);

endmodule

`default_nettype wire

// File: sd_reader/sd_block_reader.sv
// SD sector sequencer
// Sets block address, starts reads and forwards bytes on a credit link
`timescale 1ns/100ps
`default_nettype none
`include "loader_params.svh"

module sd_block_reader (
  input  wire                        clk,
  input  wire                        clk_spi,
  input  wire loader_pkg::byte_t     sd_dout,
  input  wire loader_pkg::byte_t     sd_status,
  input  wire loader_pkg::sector_t   total_sectors,
  input  wire                        stop,
  input  wire                        byte_credit,
  output loader_pkg::sd_reg_e        sd_reg_addr,
  output loader_pkg::byte_t          sd_din,
  output logic                       sd_wr,
  output logic                       sd_rd,
  output logic                       byte_valid,
  output loader_pkg::byte_t          byte_data
);

  localparam int CRED_W = $clog2(`LOADER_FIFO_DEPTH + 1);
  localparam int CNT_W  = $clog2(`LOADER_SECTOR_BYTES + 1);

  typedef enum logic [2:0] {
    ST_INIT, ST_IDLE, ST_ADDR, ST_ADDR_GAP, ST_READ, ST_TAKE, ST_PUSH, ST_END
  } state_e;

  state_e                     state;
  logic [CRED_W-1:0]          credits;
  logic [CNT_W-1:0]           byte_cnt;
  logic [1:0]                 step;         // Address write index
  loader_pkg::sector_t        sector_cnt;
  loader_pkg::sector_t        sector_limit;
  loader_pkg::sd_block_addr_t block_addr;
  logic                       init_busy;
  logic                       block_busy;
  logic                       rx_ready;

  assign init_busy  = sd_status[`LOADER_ST_INIT_BUSY];
  assign block_busy = sd_status[`LOADER_ST_BLOCK_BUSY];
  assign rx_ready   = sd_status[`LOADER_ST_RX_READY];

  // Header not parsed yet so read one sector
  assign sector_limit = (total_sectors == '0) ? loader_pkg::sector_t'(1) : total_sectors;

  // ====================
  // FIFO credits
  // ====================
  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      credits <= CRED_W'(`LOADER_FIFO_DEPTH);
    end else begin
      credits <= credits + CRED_W'(byte_credit) - CRED_W'(byte_valid);
    end
  end

  // ====================
  // Sector sequencer
  // ====================
  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      state       <= ST_INIT;
      sd_reg_addr <= loader_pkg::SD_REG_DATA;
      sd_din      <= '0;
      sd_wr       <= 1'b0;
      sd_rd       <= 1'b0;
      byte_valid  <= 1'b0;
      step        <= '0;
      byte_cnt    <= '0;
      sector_cnt  <= '0;
      block_addr  <= '0;
    end else begin
      sd_wr      <= 1'b0;   // Strobes last one cycle
      sd_rd      <= 1'b0;
      byte_valid <= 1'b0;
      case (state)
        ST_INIT: if (!init_busy) state <= ST_IDLE;
        ST_IDLE: begin
          if (!stop && !block_busy && sector_cnt < sector_limit) begin
            step  <= '0;
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          sd_wr <= 1'b1;
          case (step)
            2'd0: begin
              sd_reg_addr <= loader_pkg::SD_REG_ADDR_LO;
              sd_din      <= block_addr[7:0];
            end
            2'd1: begin
              sd_reg_addr <= loader_pkg::SD_REG_ADDR_MID;
              sd_din      <= block_addr[15:8];
            end
            2'd2: begin
              sd_reg_addr <= loader_pkg::SD_REG_ADDR_HI;
              sd_din      <= block_addr[23:16];
            end
            default: begin
              sd_reg_addr <= loader_pkg::SD_REG_CMD;  // Zero starts a read
              sd_din      <= '0;
            end
          endcase
          state <= ST_ADDR_GAP;
        end
        ST_ADDR_GAP: begin
          step <= step + 2'd1;
          if (step == 2'd3) begin
            byte_cnt <= '0;
            state    <= ST_READ;
          end else begin
            state <= ST_ADDR;
          end
        end
        ST_READ: begin
          if (stop) begin
            state <= ST_IDLE;                      // Parser rejected the image
          end else if (byte_cnt == CNT_W'(`LOADER_SECTOR_BYTES)) begin
            state <= ST_END;
          end else if (rx_ready && credits != '0) begin
            sd_reg_addr <= loader_pkg::SD_REG_DATA;
            sd_rd       <= 1'b1;
            state       <= ST_TAKE;
          end
        end
        ST_TAKE: begin                             // sd_dout valid with sd_rd
          byte_valid <= 1'b1;
          byte_cnt   <= byte_cnt + 1'b1;
          state      <= ST_PUSH;
        end
        ST_PUSH: state <= ST_READ;                 // Credit spent this cycle
        ST_END: begin
          if (!block_busy) begin
            sector_cnt <= sector_cnt + 1'b1;
            block_addr <= block_addr + 1'b1;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_INIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_TAKE) byte_data <= sd_dout;
  end

  a_valid_has_credit: assert property (@(posedge clk) disable iff (clk_spi)
    byte_valid |-> credits != '0);
  a_strobes_exclusive: assert property (@(posedge clk) disable iff (clk_spi)
    !(sd_wr && sd_rd));

endmodule

`default_nettype wire

// File: verilog/rom_loader.sv
// Cartridge loader top
// SD sector reader, credit FIFO and iNES parser
`timescale 1ns/100ps
`default_nettype none

module rom_loader (
  input  wire                       clk,
  input  wire                       clk_spi,
  input  wire loader_pkg::byte_t    sd_dout,
  input  wire loader_pkg::byte_t    sd_status,
  input  wire                       mem_credit,
  output loader_pkg::sd_reg_e       sd_reg_addr,
  output loader_pkg::byte_t         sd_din,
  output logic                      sd_wr,
  output logic                      sd_rd,
  output logic                      load_write,
  output loader_pkg::load_addr_t    load_addr,
  output loader_pkg::byte_t         load_data,
  output loader_pkg::mapper_flags_t mapper_flags,
  output logic                      done,
  output logic                      error
);

  // Reader to FIFO
  wire                 byte_valid;
  wire                 byte_credit;
  loader_pkg::byte_t   byte_data;
  // FIFO to parser
  wire                 fifo_valid;
  wire                 fifo_pop;
  loader_pkg::byte_t   fifo_data;
  loader_pkg::sector_t total_sectors;   // Parser tells reader how far to go

  sd_block_reader u_reader (
    .clk, .clk_spi, .sd_dout, .sd_status, .total_sectors,
    .stop(error), .byte_credit, .sd_reg_addr, .sd_din, .sd_wr, .sd_rd,
    .byte_valid, .byte_data
  );

  credit_fifo u_fifo (
    .clk, .clk_spi, .byte_valid, .byte_data, .fifo_pop,
    .fifo_valid, .fifo_data, .byte_credit
  );

  ines_parser u_parser (
    .clk, .clk_spi, .fifo_valid, .fifo_data, .mem_credit, .fifo_pop,
    .load_write, .load_addr, .load_data, .mapper_flags, .total_sectors,
    .done, .error
  );

endmodule

`default_nettype wire

// File: verif/sd_card_model.sv
// Behavioral SD controller register port
// Header bytes come from the testbench and the body follows a fixed byte rule
`timescale 1ns/100ps
`default_nettype none
`include "loader_params.svh"

module sd_card_model (
  input  wire                      clk,
  input  wire                      clk_spi,
  input  wire [127:0]              header,        // Byte k at bits 8k+7:8k
  input  wire loader_pkg::sd_reg_e sd_reg_addr,
  input  wire loader_pkg::byte_t   sd_din,
  input  wire                      sd_wr,
  input  wire                      sd_rd,
  output loader_pkg::byte_t        sd_dout,
  output loader_pkg::byte_t        sd_status
);

  loader_pkg::sd_block_addr_t block_addr;
  logic [9:0]                 byte_idx;
  logic [3:0]                 init_cnt;
  logic [2:0]                 delay;
  logic                       busy;
  logic                       ready;
  logic [33:0]                image_pos;

  assign image_pos = {1'b0, block_addr, 9'b0} + 34'(byte_idx);

  // Header first, then low byte of the position XOR 5A
  function automatic loader_pkg::byte_t image_byte(input logic [33:0] k);
    if (k < 34'd16) return header[{k[3:0], 3'b000} +: 8];
    return k[7:0] ^ 8'h5A;
  endfunction

  always_comb begin
    sd_status = '0;
    sd_status[`LOADER_ST_INIT_BUSY]  = (init_cnt != '0);
    sd_status[`LOADER_ST_BLOCK_BUSY] = busy;
    sd_status[`LOADER_ST_RX_READY]   = ready;
  end

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      block_addr <= '0;
      byte_idx   <= '0;
      init_cnt   <= 4'd8;                 // Card init takes a few cycles
      delay      <= '0;
      busy       <= 1'b0;
      ready      <= 1'b0;
      sd_dout    <= '0;
    end else begin
      if (init_cnt != '0) init_cnt <= init_cnt - 1'b1;
      if (sd_wr) begin
        case (sd_reg_addr)
          loader_pkg::SD_REG_ADDR_LO:  block_addr[7:0]   <= sd_din;
          loader_pkg::SD_REG_ADDR_MID: block_addr[15:8]  <= sd_din;
          loader_pkg::SD_REG_ADDR_HI:  block_addr[23:16] <= sd_din;
          loader_pkg::SD_REG_CMD: begin
            if (sd_din == '0) begin
              busy     <= 1'b1;
              byte_idx <= '0;
              delay    <= 3'd2;
            end
          end
          default: ;
        endcase
      end
      if (sd_rd && ready) begin
        ready    <= 1'b0;
        byte_idx <= byte_idx + 1'b1;
        delay    <= {1'b0, byte_idx[1:0]};  // Next byte after 0 to 3 idle cycles
      end else if (busy && !ready) begin
        if (byte_idx == 10'(`LOADER_SECTOR_BYTES)) busy <= 1'b0;
        else if (delay != '0) delay <= delay - 1'b1;
        else begin
          sd_dout <= image_byte(image_pos);
          ready   <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_rom_loader.sv
// Cartridge loader testbench
// Clock, LFSR credits, memory-side monitor, directed tests and watchdog
`timescale 1ns/100ps
`default_nettype none
`include "loader_params.svh"

module tb_rom_loader;

  // Bytes read from the card over all five tests
  localparam int TOTAL_BYTES   = (49 + 33 + 1 + 1 + 49) * `LOADER_SECTOR_BYTES;
  localparam int CYCLE_LIMIT   = TOTAL_BYTES * 12;   // 1.5 x bytes x 8

  logic                      clk;
  logic                      clk_spi;
  logic                      mem_credit;
  logic [127:0]              header;
  loader_pkg::byte_t         sd_dout;
  loader_pkg::byte_t         sd_status;
  loader_pkg::sd_reg_e       sd_reg_addr;
  loader_pkg::byte_t         sd_din;
  logic                      sd_wr;
  logic                      sd_rd;
  logic                      load_write;
  loader_pkg::load_addr_t    load_addr;
  loader_pkg::byte_t         load_data;
  loader_pkg::mapper_flags_t mapper_flags;
  logic                      done;
  logic                      error;

  logic [31:0] lfsr_state;
  logic [2:0]  rnd_bits;
  bit          random_credits;
  int          prg_bytes;
  int          exp_writes;
  int          wr_count;
  int          granted;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  logic [21:0] exp_addr;
  logic [7:0]  exp_data;

  rom_loader dut (
    .clk, .clk_spi, .sd_dout, .sd_status, .mem_credit, .sd_reg_addr, .sd_din,
    .sd_wr, .sd_rd, .load_write, .load_addr, .load_data, .mapper_flags, .done, .error
  );

  sd_card_model u_sd_model (
    .clk, .clk_spi, .header, .sd_reg_addr, .sd_din, .sd_wr, .sd_rd, .sd_dout, .sd_status
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [2:0] size_code_of(input int units);
    int n;
    n = 0;
    while (n < 7 && (1 << n) < units) n++;
    return 3'(n);
  endfunction

  function automatic logic [127:0] make_header(input logic [7:0] magic3, input logic [7:0] prg,
                                               input logic [7:0] chr, input logic [7:0] f6);
    return {64'h0, 8'h00, f6, chr, prg, magic3, 8'h53, 8'h45, 8'h4E};
  endfunction

  function automatic loader_pkg::mapper_flags_t flags_for(input logic [7:0] f6,
                                                         input int prg, input int chr);
    loader_pkg::mapper_flags_t f;
    f             = '0;
    f.mapper      = {4'h0, f6[7:4]};          // Flag byte 7 is zero in every test
    f.prg_size    = size_code_of(prg);
    f.chr_size    = size_code_of(chr);
    f.mirroring   = f6[0];
    f.has_chr_ram = (chr == 0);
    f.flags6_lo   = f6[3:0];
    return f;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  // ====================
  // Memory side
  // ====================
  always @(negedge clk) begin
    if (clk_spi) begin
      wr_count   = 0;
      granted    = 0;
      mem_credit = 1'b0;
    end else begin
      if (load_write) begin
        if (wr_count >= exp_writes) begin
          report_problem("load_write beyond the expected image size");
        end else begin
          exp_addr = (wr_count < prg_bytes) ? 22'(wr_count) :
                     `LOADER_CHR_BASE + 22'(wr_count - prg_bytes);
          exp_data = 8'(16 + wr_count) ^ 8'h5A;   // Image byte right after the header
          if (load_addr !== exp_addr) report_mismatch("load_addr", load_addr, exp_addr);
          if (load_data !== exp_data) report_mismatch("load_data", load_data, exp_data);
        end
        wr_count++;
        if (wr_count > `LOADER_MEM_CREDITS + granted)
          report_problem("memory write issued without a credit");
      end
      rnd_bits = 3'b111;
      if (random_credits && wr_count > granted) begin
        for (int b = 0; b < 3; b++) begin
          lfsr_state  = lfsr_next(lfsr_state);
          rnd_bits[b] = lfsr_state[0];
        end
      end
      mem_credit = (wr_count > granted) && (rnd_bits == 3'b111);  // 1 in 8 when random
      if (mem_credit) granted++;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    clk_spi = 1'b1;
    repeat (2) @(negedge clk);
    clk_spi = 1'b0;
  endtask

  task automatic run_load(input string name, input logic [127:0] hdr, input bit rnd,
                          input int prg, input int chr, input bit bad);
    int errs_before;
    loader_pkg::mapper_flags_t exp_flags;
    errs_before    = errors;
    header         = hdr;
    random_credits = rnd;
    prg_bytes      = 16384 * prg;
    exp_writes     = bad ? 0 : 16384 * prg + 8192 * chr;
    exp_flags      = flags_for(hdr[55:48], prg, chr);
    apply_reset();
    while (!done && !error) @(negedge clk);
    repeat (16) @(negedge clk);               // Quiet window for stray writes
    if (bad) begin
      if (error !== 1'b1) report_problem("error did not rise for a bad header");
      if (done !== 1'b0) report_mismatch("done", done, 0);
    end else begin
      if (error !== 1'b0) report_problem("error rose for a valid header");
      if (done !== 1'b1) report_mismatch("done", done, 1);
      if (mapper_flags !== exp_flags) report_mismatch("mapper_flags", mapper_flags, exp_flags);
      if (chr == 0 && mapper_flags.has_chr_ram !== 1'b1)
        report_problem("has-CHR-RAM flag not set for a CHR count of zero");
    end
    if (wr_count != exp_writes) report_mismatch("write count", wr_count, exp_writes);
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("Test %s: %s, %0d writes", name, (errors == errs_before) ? "ok" : "mismatch",
             wr_count);
  endtask

  task automatic test_mapper2_vertical();
    run_load("mapper 2 vertical", make_header(8'h1A, 8'd1, 8'd1, 8'h21), 1'b0, 1, 1, 1'b0);
  endtask

  task automatic test_chr_ram();
    run_load("CHR RAM", make_header(8'h1A, 8'd1, 8'd0, 8'h10), 1'b0, 1, 0, 1'b0);
  endtask

  task automatic test_bad_magic();
    run_load("bad magic", make_header(8'h1B, 8'd1, 8'd1, 8'h21), 1'b0, 1, 1, 1'b1);
  endtask

  task automatic test_trainer_flag();
    run_load("flag 6 bit 2", make_header(8'h1A, 8'd1, 8'd1, 8'h04), 1'b0, 1, 1, 1'b1);
  endtask

  task automatic test_random_credits();
    run_load("random credits", make_header(8'h1A, 8'd1, 8'd1, 8'h21), 1'b1, 1, 1, 1'b0);
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: no end of load after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    clk_spi        = 1'b1;
    mem_credit     = 1'b0;
    header         = '0;
    random_credits = 1'b0;
    prg_bytes      = 0;
    exp_writes     = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    cycles         = 0;
    lfsr_state     = 32'h5362_9b95;
    test_mapper2_vertical();
    test_chr_ram();
    test_bad_magic();
    test_trainer_flag();
    test_random_credits();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/loader_pkg.sv
cart_loader/credit_fifo.sv
cart_loader/ines_parser.sv
sd_reader/sd_block_reader.sv
verilog/rom_loader.sv
verif/sd_card_model.sv
verif/tb_rom_loader.sv
